// ==== hdl/axil_bridge_pkg.sv ====
////////////////////////////////////////
// Shared widths, fixed IDs and channel payloads
// for the AXI-lite to AXI4 SRAM subsystem.
// Modules take it by a wildcard import.
////////////////////////////////////////
package axil_bridge_pkg;

	// Bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W/8;
	localparam int ID_W   = 4;

	// Fixed IDs used by the bridge on the AXI4 side
	localparam logic [ID_W-1:0] WRITE_ID = 4'h1;
	localparam logic [ID_W-1:0] READ_ID  = 4'h2;

	// Byte offset bits, doubles as the AXI size code
	localparam int ADDR_LSB = 2;

	// SRAM depth and word index width
	localparam int MEM_WORDS = 256;
	localparam int IDX_W     = $clog2(MEM_WORDS);

	// Response codes
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	////////////////////////////////////////
	// AXI-lite payloads
	////////////////////////////////////////

	// Shared by AW and AR
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [2:0]        prot;
	} axil_aw_t;

	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [STRB_W-1:0] strb;
	} axil_w_t;

	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [1:0]        resp;
	} axil_r_t;

	////////////////////////////////////////
	// AXI4 payloads
	////////////////////////////////////////

	// Shared by AW and AR
	typedef struct packed {
		logic [ID_W-1:0]   id;
		logic [ADDR_W-1:0] addr;
		logic [7:0]        len;
		logic [2:0]        size;
		logic [1:0]        burst;
		logic              lock;
		logic [3:0]        cache;
		logic [2:0]        prot;
		logic [3:0]        qos;
	} axi_a_t;

	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [STRB_W-1:0] strb;
		logic              last;
	} axi_w_t;

	typedef struct packed {
		logic [ID_W-1:0] id;
		logic [1:0]      resp;
	} axi_b_t;

	typedef struct packed {
		logic [ID_W-1:0]   id;
		logic [DATA_W-1:0] data;
		logic              last;
		logic [1:0]        resp;
	} axi_r_t;

	// Address split as seen by the SRAM
	typedef struct packed {
		logic [ADDR_W-IDX_W-ADDR_LSB-1:0] hi;
		logic [IDX_W-1:0]                 idx;
		logic [ADDR_LSB-1:0]              off;
	} axi_addr_fields_t;

	typedef union packed {
		logic [ADDR_W-1:0] raw;
		axi_addr_fields_t  f;
	} axi_addr_u;

endpackage

// ==== hdl/axil_req_slice.sv ====
////////////////////////////////////////
// Request register slice on the AXI-lite
// side. One entry per AW, W and AR channel
// breaks the ready path toward the master.
////////////////////////////////////////
`timescale 1ns/10ps

module axil_req_slice
	import axil_bridge_pkg::*;
(
	input  logic     i_aclk,
	input  logic     i_reset,
	// Write address in and out
	input  logic     i_aw_valid,
	output logic     o_aw_ready,
	input  axil_aw_t i_aw,
	output logic     o_aw_valid,
	input  logic     i_aw_ready,
	output axil_aw_t o_aw,
	// Write data in and out
	input  logic     i_w_valid,
	output logic     o_w_ready,
	input  axil_w_t  i_w,
	output logic     o_w_valid,
	input  logic     i_w_ready,
	output axil_w_t  o_w,
	// Read address in and out
	input  logic     i_ar_valid,
	output logic     o_ar_ready,
	input  axil_aw_t i_ar,
	output logic     o_ar_valid,
	input  logic     i_ar_ready,
	output axil_aw_t o_ar
);

	// Control vectors, bit 0 AW, bit 1 W, bit 2 AR
	logic [2:0] in_valid;
	logic [2:0] in_ready;
	logic [2:0] out_ready;
	logic [2:0] full;
	logic [2:0] load;

	assign in_valid  = {i_ar_valid, i_w_valid, i_aw_valid};
	assign out_ready = {i_ar_ready, i_w_ready, i_aw_ready};

	// Open while empty, or when the held entry leaves this cycle
	assign in_ready = ~full | out_ready;
	assign load     = in_valid & in_ready;

	assign {o_ar_ready, o_w_ready, o_aw_ready} = in_ready;
	assign {o_ar_valid, o_w_valid, o_aw_valid} = full;

	////////////////////////////////////////
	// Full flags
	////////////////////////////////////////

	always_ff @(posedge i_aclk)
	begin
		if (i_reset)
			full <= '0;
		else
			// Set on a load, clear on a drain with nothing behind it
			full <= load | (full & ~out_ready);
	end

	////////////////////////////////////////
	// Payload registers
	////////////////////////////////////////

	always_ff @(posedge i_aclk)
	begin
		if (load[0])
			o_aw <= i_aw;
		if (load[1])
			o_w <= i_w;
		if (load[2])
			o_ar <= i_ar;
	end

endmodule

// ==== hdl/axil_to_axi.sv ====
////////////////////////////////////////
// AXI-lite to single-beat AXI4 bridge.
// Fills the fixed AXI4 fields, passes all
// handshakes through, and turns a bad ID
// or missing RLAST into SLVERR.
////////////////////////////////////////
`timescale 1ns/10ps

module axil_to_axi
	import axil_bridge_pkg::*;
(
	// AXI-lite slave side
	input  logic       i_aw_valid,
	output logic       o_aw_ready,
	input  axil_aw_t   i_aw,
	input  logic       i_w_valid,
	output logic       o_w_ready,
	input  axil_w_t    i_w,
	output logic       o_b_valid,
	input  logic       i_b_ready,
	output logic [1:0] o_b_resp,
	input  logic       i_ar_valid,
	output logic       o_ar_ready,
	input  axil_aw_t   i_ar,
	output logic       o_r_valid,
	input  logic       i_r_ready,
	output axil_r_t    o_r,
	// AXI4 master side
	output logic       o_m_aw_valid,
	input  logic       i_m_aw_ready,
	output axi_a_t     o_m_aw,
	output logic       o_m_w_valid,
	input  logic       i_m_w_ready,
	output axi_w_t     o_m_w,
	input  logic       i_m_b_valid,
	output logic       o_m_b_ready,
	input  axi_b_t     i_m_b,
	output logic       o_m_ar_valid,
	input  logic       i_m_ar_ready,
	output axi_a_t     o_m_ar,
	input  logic       i_m_r_valid,
	output logic       o_m_r_ready,
	input  axi_r_t     i_m_r
);

	// Single beat, full width, FIXED burst, bufferable and modifiable
	function automatic axi_a_t fill_a(input axil_aw_t a, input logic [ID_W-1:0] id);
		axi_a_t res;
		res.id    = id;
		res.addr  = a.addr;
		res.len   = 8'd0;
		res.size  = 3'(ADDR_LSB);
		res.burst = 2'b00;
		res.lock  = 1'b0;
		res.cache = 4'b0011;
		res.prot  = a.prot;
		res.qos   = 4'd0;
		return res;
	endfunction

	// Requests
	assign o_m_aw       = fill_a(i_aw, WRITE_ID);
	assign o_m_aw_valid = i_aw_valid;
	assign o_aw_ready   = i_m_aw_ready;

	assign o_m_w       = '{data: i_w.data, strb: i_w.strb, last: 1'b1};
	assign o_m_w_valid = i_w_valid;
	assign o_w_ready   = i_m_w_ready;

	assign o_m_ar       = fill_a(i_ar, READ_ID);
	assign o_m_ar_valid = i_ar_valid;
	assign o_ar_ready   = i_m_ar_ready;

	// Responses, checked against the IDs sent out
	assign o_b_resp    = (i_m_b.id != WRITE_ID) ? RESP_SLVERR : i_m_b.resp;
	assign o_b_valid   = i_m_b_valid;
	assign o_m_b_ready = i_b_ready;

	assign o_r.data    = i_m_r.data;
	assign o_r.resp    = (i_m_r.id != READ_ID || !i_m_r.last) ? RESP_SLVERR : i_m_r.resp;
	assign o_r_valid   = i_m_r_valid;
	assign o_m_r_ready = i_r_ready;

endmodule

// ==== hdl/axi_sram.sv ====
////////////////////////////////////////
// Single-beat AXI4 SRAM target with byte
// strobes. Addresses past the memory give
// SLVERR, and B and R are held until taken.
////////////////////////////////////////
`timescale 1ns/10ps

module axi_sram
	import axil_bridge_pkg::*;
(
	input  logic   i_aclk,
	input  logic   i_reset,
	// Write address and data
	input  logic   i_aw_valid,
	output logic   o_aw_ready,
	input  axi_a_t i_aw,
	input  logic   i_w_valid,
	output logic   o_w_ready,
	input  axi_w_t i_w,
	// Write response
	output logic   o_b_valid,
	input  logic   i_b_ready,
	output axi_b_t o_b,
	// Read address and data
	input  logic   i_ar_valid,
	output logic   o_ar_ready,
	input  axi_a_t i_ar,
	output logic   o_r_valid,
	input  logic   i_r_ready,
	output axi_r_t o_r
);

	logic [DATA_W-1:0] mem [MEM_WORDS];

	axi_addr_u aw_addr;
	axi_addr_u ar_addr;
	logic      aw_in_range;
	logic      ar_in_range;
	logic      wr_take;
	logic      rd_take;

	// Word index and range check come from the address fields
	assign aw_addr.raw = i_aw.addr;
	assign ar_addr.raw = i_ar.addr;
	assign aw_in_range = (aw_addr.f.hi == '0);
	assign ar_in_range = (ar_addr.f.hi == '0);

	////////////////////////////////////////
	// Request acceptance
	////////////////////////////////////////

	// AW and W go in together, and only with the B slot free
	assign o_aw_ready = i_w_valid && !o_b_valid;
	assign o_w_ready  = i_aw_valid && !o_b_valid;
	assign wr_take    = i_aw_valid && i_w_valid && !o_b_valid;

	// One read held at a time
	assign o_ar_ready = !o_r_valid;
	assign rd_take    = i_ar_valid && !o_r_valid;

	////////////////////////////////////////
	// Memory array
	////////////////////////////////////////

	always_ff @(posedge i_aclk)
	begin
		if (wr_take && aw_in_range)
		begin
			// Only the lanes with their strobe set
			for (int lane = 0; lane < STRB_W; lane++)
			begin
				if (i_w.strb[lane])
					mem[aw_addr.f.idx][lane*8 +: 8] <= i_w.data[lane*8 +: 8];
			end
		end
	end

	////////////////////////////////////////
	// Response valids
	////////////////////////////////////////

	always_ff @(posedge i_aclk)
	begin
		if (i_reset)
		begin
			o_b_valid <= 1'b0;
			o_r_valid <= 1'b0;
		end
		else
		begin
			// Raised on acceptance, held until the master takes it
			if (wr_take)
				o_b_valid <= 1'b1;
			else if (i_b_ready)
				o_b_valid <= 1'b0;
			if (rd_take)
				o_r_valid <= 1'b1;
			else if (i_r_ready)
				o_r_valid <= 1'b0;
		end
	end

	////////////////////////////////////////
	// Response payloads
	////////////////////////////////////////

	always_ff @(posedge i_aclk)
	begin
		if (wr_take)
		begin
			o_b.id   <= i_aw.id;
			o_b.resp <= aw_in_range ? RESP_OKAY : RESP_SLVERR;
		end
		if (rd_take)
		begin
			o_r.id   <= i_ar.id;
			o_r.last <= 1'b1;
			// Out of range reads return zero data
			o_r.data <= ar_in_range ? mem[ar_addr.f.idx] : '0;
			o_r.resp <= ar_in_range ? RESP_OKAY : RESP_SLVERR;
		end
	end

endmodule

// ==== hdl/axil_mem_top.sv ====
////////////////////////////////////////
// Top level of the AXI-lite memory store.
// Chains the request slice, the AXI4
// bridge and the SRAM target.
////////////////////////////////////////
`timescale 1ns/10ps

module axil_mem_top
	import axil_bridge_pkg::*;
(
	input  logic       i_aclk,
	input  logic       i_reset,
	// AXI-lite slave port
	input  logic       i_aw_valid,
	output logic       o_aw_ready,
	input  axil_aw_t   i_aw,
	input  logic       i_w_valid,
	output logic       o_w_ready,
	input  axil_w_t    i_w,
	output logic       o_b_valid,
	input  logic       i_b_ready,
	output logic [1:0] o_b_resp,
	input  logic       i_ar_valid,
	output logic       o_ar_ready,
	input  axil_aw_t   i_ar,
	output logic       o_r_valid,
	input  logic       i_r_ready,
	output axil_r_t    o_r
);

	// Slice to bridge, AXI-lite
	logic     s_aw_valid, s_aw_ready;
	axil_aw_t s_aw;
	logic     s_w_valid, s_w_ready;
	axil_w_t  s_w;
	logic     s_ar_valid, s_ar_ready;
	axil_aw_t s_ar;

	// Bridge to SRAM, AXI4
	logic   m_aw_valid, m_aw_ready;
	axi_a_t m_aw;
	logic   m_w_valid, m_w_ready;
	axi_w_t m_w;
	logic   m_b_valid, m_b_ready;
	axi_b_t m_b;
	logic   m_ar_valid, m_ar_ready;
	axi_a_t m_ar;
	logic   m_r_valid, m_r_ready;
	axi_r_t m_r;

	axil_req_slice u_slice (
		.i_aclk     (i_aclk),
		.i_reset    (i_reset),
		.i_aw_valid (i_aw_valid),
		.o_aw_ready (o_aw_ready),
		.i_aw       (i_aw),
		.o_aw_valid (s_aw_valid),
		.i_aw_ready (s_aw_ready),
		.o_aw       (s_aw),
		.i_w_valid  (i_w_valid),
		.o_w_ready  (o_w_ready),
		.i_w        (i_w),
		.o_w_valid  (s_w_valid),
		.i_w_ready  (s_w_ready),
		.o_w        (s_w),
		.i_ar_valid (i_ar_valid),
		.o_ar_ready (o_ar_ready),
		.i_ar       (i_ar),
		.o_ar_valid (s_ar_valid),
		.i_ar_ready (s_ar_ready),
		.o_ar       (s_ar)
	);

	// Responses go straight from the bridge to the outside ports
	axil_to_axi u_bridge (
		.i_aw_valid   (s_aw_valid),
		.o_aw_ready   (s_aw_ready),
		.i_aw         (s_aw),
		.i_w_valid    (s_w_valid),
		.o_w_ready    (s_w_ready),
		.i_w          (s_w),
		.o_b_valid    (o_b_valid),
		.i_b_ready    (i_b_ready),
		.o_b_resp     (o_b_resp),
		.i_ar_valid   (s_ar_valid),
		.o_ar_ready   (s_ar_ready),
		.i_ar         (s_ar),
		.o_r_valid    (o_r_valid),
		.i_r_ready    (i_r_ready),
		.o_r          (o_r),
		.o_m_aw_valid (m_aw_valid),
		.i_m_aw_ready (m_aw_ready),
		.o_m_aw       (m_aw),
		.o_m_w_valid  (m_w_valid),
		.i_m_w_ready  (m_w_ready),
		.o_m_w        (m_w),
		.i_m_b_valid  (m_b_valid),
		.o_m_b_ready  (m_b_ready),
		.i_m_b        (m_b),
		.o_m_ar_valid (m_ar_valid),
		.i_m_ar_ready (m_ar_ready),
		.o_m_ar       (m_ar),
		.i_m_r_valid  (m_r_valid),
		.o_m_r_ready  (m_r_ready),
		.i_m_r        (m_r)
	);

	axi_sram u_sram (
		.i_aclk     (i_aclk),
		.i_reset    (i_reset),
		.i_aw_valid (m_aw_valid),
		.o_aw_ready (m_aw_ready),
		.i_aw       (m_aw),
		.i_w_valid  (m_w_valid),
		.o_w_ready  (m_w_ready),
		.i_w        (m_w),
		.o_b_valid  (m_b_valid),
		.i_b_ready  (m_b_ready),
		.o_b        (m_b),
		.i_ar_valid (m_ar_valid),
		.o_ar_ready (m_ar_ready),
		.i_ar       (m_ar),
		.o_r_valid  (m_r_valid),
		.i_r_ready  (m_r_ready),
		.o_r        (m_r)
	);

endmodule

// ==== bench/axil_mem_assert.sv ====
////////////////////////////////////////
// Handshake assertions on the outside
// response channels, bound to the top level
////////////////////////////////////////
`timescale 1ns/10ps

module axil_mem_assert
	import axil_bridge_pkg::*;
(
	input logic       i_aclk,
	input logic       i_reset,
	input logic       i_b_valid,
	input logic       i_b_ready,
	input logic [1:0] i_b_resp,
	input logic       i_r_valid,
	input logic       i_r_ready,
	input axil_r_t    i_r
);

	// Failure tally, read by the testbench at the end
	int unsigned violations = 0;

	// No response may show while reset is applied
	a_reset_quiet: assert property (@(posedge i_aclk)
		$past(i_reset) |-> (!i_b_valid && !i_r_valid))
		else
		begin
			violations++;
			$error("Response valid high during reset");
		end

	// B stays up with the same code until taken
	a_b_hold: assert property (@(posedge i_aclk) disable iff (i_reset)
		(i_b_valid && !i_b_ready) |=> (i_b_valid && $stable(i_b_resp)))
		else
		begin
			violations++;
			$error("B dropped or changed while stalled");
		end

	// R payload frozen while stalled
	a_r_hold: assert property (@(posedge i_aclk) disable iff (i_reset)
		(i_r_valid && !i_r_ready) |=> (i_r_valid && $stable(i_r)))
		else
		begin
			violations++;
			$error("R dropped or changed while stalled");
		end

endmodule

bind axil_mem_top axil_mem_assert u_assert (
	.i_aclk    (i_aclk),
	.i_reset   (i_reset),
	.i_b_valid (o_b_valid),
	.i_b_ready (i_b_ready),
	.i_b_resp  (o_b_resp),
	.i_r_valid (o_r_valid),
	.i_r_ready (i_r_ready),
	.i_r       (o_r)
);

// ==== bench/tb_axil_mem.sv ====
////////////////////////////////////////
// Testbench for the AXI-lite memory store.
// Replays the vector file twice, first with
// idle gaps, then back to back with random
// B and R stalls, and checks every response.
////////////////////////////////////////
`timescale 1ns/10ps

module tb_axil_mem
	import axil_bridge_pkg::*;
;

	localparam int N_VEC        = 19;
	localparam int VEC_FIELDS   = 6;
	localparam int VEC_WORDS    = 128;
	localparam int RESET_CYCLES = 16;
	// Two passes, each vector gets a generous budget
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + 2*N_VEC*64;

	logic       i_aclk = 1'b0;
	logic       i_reset;
	logic       i_aw_valid;
	logic       o_aw_ready;
	axil_aw_t   i_aw;
	logic       i_w_valid;
	logic       o_w_ready;
	axil_w_t    i_w;
	logic       o_b_valid;
	logic       i_b_ready;
	logic [1:0] o_b_resp;
	logic       i_ar_valid;
	logic       o_ar_ready;
	axil_aw_t   i_ar;
	logic       o_r_valid;
	logic       i_r_ready;
	axil_r_t    o_r;

	// Op, address, data, strobe, response, read data
	logic [31:0] vec_mem [VEC_WORDS];

	int seed;
	bit stall_on;
	int checks;
	int errors;
	int vectors_run;

	axil_mem_top dut (.*);

	// 8 ns period
	always #4 i_aclk = ~i_aclk;

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	function automatic logic [31:0] vector_word(input int n, input int k);
		return vec_mem[7'(n*VEC_FIELDS + k)];
	endfunction

	// Ready for B and R, dropped about one cycle in four when stalling
	function automatic logic pick_ready();
		if (!stall_on)
			return 1'b1;
		return (($random(seed) & 32'sd3) != 0);
	endfunction

	task automatic check_bresp(input logic [1:0] got, input logic [1:0] exp, input int n);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %0t: vector %0d write resp %0h, expected %0h", $time, n, got, exp);
		end
	endtask

	task automatic check_read(input axil_r_t got, input axil_r_t exp, input int n);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %0t: vector %0d read data %h resp %0h, expected %h resp %0h",
				$time, n, got.data, got.resp, exp.data, exp.resp);
		end
	endtask

	// Only one request is ever in flight, so nothing may follow a response
	task automatic confirm_quiet(input int n);
		if (o_b_valid || o_r_valid)
		begin
			errors++;
			$display("Extra response seen after vector %0d at time %0t", n, $time);
		end
	endtask

	// Called on a falling edge, returns on a falling edge
	task automatic write_word(input int n);
		logic [31:0] word;
		logic [1:0]  exp_resp;
		bit          aw_pend;
		bit          w_pend;
		bit          aw_hit;
		bit          w_hit;
		bit          taken;
		word          = vector_word(n, 3);
		i_aw.addr     = vector_word(n, 1);
		i_aw.prot     = 3'b000;
		i_w.data      = vector_word(n, 2);
		i_w.strb      = word[STRB_W-1:0];
		word          = vector_word(n, 4);
		exp_resp      = word[1:0];
		i_aw_valid    = 1'b1;
		i_w_valid     = 1'b1;
		aw_pend       = 1'b1;
		w_pend        = 1'b1;
		// AW and W may be taken in different cycles
		while (aw_pend || w_pend)
		begin
			aw_hit = aw_pend && o_aw_ready;
			w_hit  = w_pend && o_w_ready;
			@(negedge i_aclk);
			if (aw_hit)
			begin
				aw_pend    = 1'b0;
				i_aw_valid = 1'b0;
			end
			if (w_hit)
			begin
				w_pend    = 1'b0;
				i_w_valid = 1'b0;
			end
		end
		taken = 1'b0;
		while (!taken)
		begin
			i_b_ready = pick_ready();
			if (o_b_valid && i_b_ready)
			begin
				check_bresp(o_b_resp, exp_resp, n);
				taken = 1'b1;
			end
			@(negedge i_aclk);
		end
		i_b_ready = 1'b0;
		confirm_quiet(n);
	endtask

	task automatic read_word(input int n);
		logic [31:0] word;
		axil_r_t     exp_r;
		bit          taken;
		word        = vector_word(n, 4);
		exp_r.data  = vector_word(n, 5);
		exp_r.resp  = word[1:0];
		i_ar.addr   = vector_word(n, 1);
		i_ar.prot   = 3'b000;
		i_ar_valid  = 1'b1;
		taken       = 1'b0;
		while (!taken)
		begin
			taken = o_ar_ready;
			@(negedge i_aclk);
		end
		i_ar_valid = 1'b0;
		taken      = 1'b0;
		while (!taken)
		begin
			i_r_ready = pick_ready();
			if (o_r_valid && i_r_ready)
			begin
				check_read(o_r, exp_r, n);
				taken = 1'b1;
			end
			@(negedge i_aclk);
		end
		i_r_ready = 1'b0;
		confirm_quiet(n);
	endtask

	// One pass over the vector list
	task automatic run_pass(input bit stalls, input bit gaps);
		stall_on = stalls;
		for (int n = 0; n < N_VEC; n++)
		begin
			if (vector_word(n, 0) == 32'd0)
				write_word(n);
			else
				read_word(n);
			vectors_run++;
			if (gaps)
				repeat (3) @(negedge i_aclk);
		end
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial
	begin
		seed        = 32'hd2f7;
		stall_on    = 1'b0;
		checks      = 0;
		errors      = 0;
		vectors_run = 0;
		i_reset     = 1'b1;
		i_aw_valid  = 1'b0;
		i_aw        = '0;
		i_w_valid   = 1'b0;
		i_w         = '0;
		i_b_ready   = 1'b0;
		i_ar_valid  = 1'b0;
		i_ar        = '0;
		i_r_ready   = 1'b0;
		$readmemh("bench/axil_mem_vectors.txt", vec_mem);
		repeat (RESET_CYCLES) @(posedge i_aclk);
		@(negedge i_aclk);
		i_reset = 1'b0;
		@(negedge i_aclk);
		// Gaps and no stalls, then back to back under back-pressure
		run_pass(1'b0, 1'b1);
		run_pass(1'b1, 1'b0);
		repeat (2) @(negedge i_aclk);
		$display("Summary: %0d vectors, %0d checks, %0d errors, %0d assertion failures",
			vectors_run, checks, errors, dut.u_assert.violations);
		if (errors == 0 && dut.u_assert.violations == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	// Watchdog
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge i_aclk);
		$display("Timeout: the DUT stopped responding before all vectors finished");
		$display("Done: errors found");
		$finish;
	end

endmodule

// ==== bench/axil_mem_vectors.txt ====
// op (0 write, 1 read), address, data, strobe, expected resp, expected read data
// Resp 0 is OKAY and 2 is SLVERR, all fields in hex
0 00000000 11223344 F 0 00000000
1 00000000 00000000 0 0 11223344
0 00000004 A5A5A5A5 F 0 00000000
0 00000004 0000BE00 2 0 00000000
1 00000004 00000000 0 0 A5A5BEA5
0 00000008 CAFEF00D F 0 00000000
0 00000008 12345678 9 0 00000000
1 00000008 00000000 0 0 12FEF078
0 00000010 DEADBEEF F 0 00000000
0 00000410 01010101 F 2 00000000
1 00000410 00000000 0 2 00000000
1 00000010 00000000 0 0 DEADBEEF
0 80000010 FFFFFFFF F 2 00000000
1 00000010 00000000 0 0 DEADBEEF
0 000003FC 0F0F0F0F F 0 00000000
1 000003FC 00000000 0 0 0F0F0F0F
1 FFFFFFFC 00000000 0 2 00000000
0 000003FC FFFFFFFF 0 0 00000000
1 000003FC 00000000 0 0 0F0F0F0F

// ==== tb.f ====
hdl/axil_bridge_pkg.sv
hdl/axil_req_slice.sv
hdl/axil_to_axi.sv
hdl/axi_sram.sv
hdl/axil_mem_top.sv
bench/axil_mem_assert.sv
bench/tb_axil_mem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing --assert -f tb.f --top-module tb_axil_mem \
	-Mdir "$BUILD_DIR" -o sim_tb; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/sim_tb" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
	echo "Simulation reported failures"
	exit 1
fi

echo "Simulation passed"
exit 0
